/* include/sprite_defs.svh */
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// object table depth and index width
`define OBJ_COUNT   64
`define OBJ_IDX_W   6

// CPU data word
`define WORD_W      16

// tiles are square, width and height in pixels
`define TILE_PIX    16

// bit 8 registers, bits 7..2 object, bits 1..0 word in entry
`define CPU_ADDR_W  9

`endif

/* logic/sprite_pkg.sv */
`include "sprite_defs.svh"

package sprite_pkg;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,   // table read issued
        S_LATCH,  // entry valid, geometry registered
        S_EVAL,   // zone decision
        S_DRAW,
        S_NEXT    // gap between two draw strobes
    } scan_state_e;

    typedef enum logic [1:0] {
        REG_XOFF = 2'd0,
        REG_YOFF = 2'd1,
        REG_CFG  = 2'd2
    } reg_addr_e;

    // one object, decoded from its four table words
    typedef struct packed {
        logic               active;
        logic [1:0]         hsz;
        logic [1:0]         vsz;
        logic               hflip;
        logic               vflip;
        logic [7:0]         attr;
        logic [9:0]         y;
        logic [9:0]         x;
        logic [`WORD_W-1:0] code;
    } obj_entry_t;

endpackage

/* logic/obj_table.sv */
`timescale 1ns/1ps
`include "sprite_defs.svh"

module obj_table
    import sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_we,
    input  logic [`CPU_ADDR_W-1:0] cpu_addr,
    input  logic [`WORD_W-1:0]     cpu_data,
    obj_rd_if.tbl                  rd
);

    logic [`WORD_W-1:0] mem [`OBJ_COUNT][4];
    logic [`WORD_W-1:0] w0, w1, w2, w3;
    reg_addr_e          sel;

    assign sel = reg_addr_e'(cpu_addr[1:0]);
    assign w0  = mem[rd.rd_idx][0];
    assign w1  = mem[rd.rd_idx][1];
    assign w2  = mem[rd.rd_idx][2];
    assign w3  = mem[rd.rd_idx][3];

    always_ff @(posedge clk) begin
        if (cpu_we && !cpu_addr[`CPU_ADDR_W-1])
            mem[cpu_addr[`OBJ_IDX_W+1:2]][cpu_addr[1:0]] <= cpu_data;
        if (rd.rd_en) begin
            // word 0 carries flags, sizes and attr, bit 14 unused
            rd.entry <= '{active: w0[15], vflip: w0[13], hflip: w0[12],
                          vsz: w0[11:10], hsz: w0[9:8], attr: w0[7:0],
                          y: w1[9:0], x: w2[9:0], code: w3};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd.xoff <= '0;
            rd.yoff <= '0;
            rd.ghf  <= 1'b0;
            rd.gvf  <= 1'b0;
        end else if (cpu_we && cpu_addr[`CPU_ADDR_W-1]) begin
            case (sel)
                REG_XOFF: rd.xoff <= cpu_data[9:0];
                REG_YOFF: rd.yoff <= cpu_data[9:0];
                REG_CFG:  {rd.gvf, rd.ghf} <= cpu_data[1:0];
                default:  ;  // selector 3 is unmapped
            endcase
        end
    end

    a_rd_idx_known: assert property (@(posedge clk) disable iff (rst)
        rd.rd_en |-> !$isunknown(rd.rd_idx));

endmodule

/* logic/tile_step_counter.sv */
`timescale 1ns/1ps

module tile_step_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [1:0] hsz,
    input  logic       advance,
    output logic [2:0] step,
    output logic       last
);

    logic [2:0] final_col;  // 2^hsz columns, minus one

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            step      <= '0;
            final_col <= '0;
        end else if (load) begin
            step      <= '0;
            final_col <= 3'b111 >> (2'd3 - hsz);
        end else if (advance) begin
            step <= step + 3'd1;
        end
    end

    assign last = (step == final_col);

    // the scanner must leave the object after its final column
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        !(advance && last && !load));

endmodule

/* logic/obj_geom.sv */
`timescale 1ns/1ps
`include "sprite_defs.svh"

module obj_geom (
    input  logic               clk,
    input  logic               rst,
    obj_rd_if.geom             rd,
    input  logic [8:0]         line,
    input  logic               eval,
    input  logic [2:0]         step,
    output logic               in_zone,
    output logic [`WORD_W-1:0] code,
    output logic [8:0]         hpos,
    output logic [3:0]         ysub,
    output logic               eff_hflip,
    output logic               eff_vflip
);

    localparam int TS = $clog2(`TILE_PIX);

    logic [9:0] row_n;
    logic [9:0] row;   // line within the object, top at 0
    logic [2:0] vmask;
    logic [2:0] hmask;
    logic [2:0] trow;
    logic [2:0] col;
    logic [2:0] code_lo;
    logic [2:0] code_mid;
    logic [9:0] hsum;

    assign row_n = {1'b0, line} + rd.yoff - rd.entry.y;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            in_zone   <= 1'b0;
            eff_hflip <= 1'b0;
            eff_vflip <= 1'b0;
        end else if (eval) begin
            in_zone   <= rd.entry.active && ((row_n >> (TS + rd.entry.vsz)) == 10'd0);
            eff_hflip <= rd.entry.hflip ^ rd.ghf;
            eff_vflip <= rd.entry.vflip ^ rd.gvf;
        end
    end

    always_ff @(posedge clk) begin
        if (eval)
            row <= row_n;
    end

    // tile counts per direction are 1, 2, 4 or 8
    assign vmask = 3'b111 >> (2'd3 - rd.entry.vsz);
    assign hmask = 3'b111 >> (2'd3 - rd.entry.hsz);

    assign trow = row[TS +: 3] ^ (eff_vflip ? vmask : 3'd0);
    assign col  = step ^ (eff_hflip ? hmask : 3'd0);

    // column in bits 2..0, tile row in bits 5..3, no carry out
    assign code_lo  = rd.entry.code[2:0] + col;
    assign code_mid = rd.entry.code[5:3] + trow;
    assign code     = {rd.entry.code[`WORD_W-1:6], code_mid, code_lo};

    // screen position always runs left to right
    assign hsum = rd.entry.x - rd.xoff + (10'(step) << TS);
    assign hpos = hsum[8:0];

    assign ysub = eff_vflip ? ~row[3:0] : row[3:0];

endmodule

/* logic/scan_fsm.sv */
`timescale 1ns/1ps
`include "sprite_defs.svh"

module scan_fsm
    import sprite_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  logic [8:0] vline,
    obj_rd_if.scanner  rd,
    input  logic       in_zone,
    input  logic       last,
    output logic       load,
    output logic       advance,
    output logic       eval,
    output logic [8:0] line,
    output logic       draw_start,
    input  logic       draw_busy,
    output logic       line_done
);

    scan_state_e           state;
    logic [`OBJ_IDX_W-1:0] idx;
    logic                  obj_end;
    logic                  last_obj;

    assign rd.rd_en  = (state == S_READ);
    assign rd.rd_idx = idx;

    // entry is valid in S_LATCH, so geometry and column count load there
    assign load = (state == S_LATCH);
    assign eval = (state == S_LATCH);

    // previous cycle is never a strobe, S_NEXT sits between two of them
    assign draw_start = (state == S_DRAW) && !draw_busy;
    assign advance    = draw_start && !last;

    assign obj_end  = ((state == S_EVAL) && !in_zone) || (draw_start && last);
    assign last_obj = (idx == `OBJ_IDX_W'(`OBJ_COUNT - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            idx       <= '0;
            line      <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (line_start) begin
                // also aborts a scan still running
                state <= S_READ;
                idx   <= '0;
                line  <= vline;
            end else if (obj_end) begin
                if (last_obj) begin
                    state     <= S_IDLE;
                    line_done <= 1'b1;
                end else begin
                    idx   <= idx + 1'b1;
                    state <= S_READ;
                end
            end else begin
                case (state)
                    S_IDLE:  state <= S_IDLE;
                    S_READ:  state <= S_LATCH;
                    S_LATCH: state <= S_EVAL;
                    S_EVAL:  state <= S_DRAW;  // in zone here
                    S_DRAW: begin
                        if (draw_start)
                            state <= S_NEXT;   // waits while busy
                    end
                    S_NEXT:  state <= S_DRAW;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // handshake seen from the drawer side
    a_draw_hs: assert property (@(posedge clk) disable iff (rst)
        $rose(draw_busy) |-> $past(draw_start));

endmodule

/* logic/sprite_scan_top.sv */
`timescale 1ns/1ps
`include "sprite_defs.svh"

interface obj_rd_if
    import sprite_pkg::*;
();
    logic                  rd_en;
    logic [`OBJ_IDX_W-1:0] rd_idx;
    obj_entry_t            entry;   // valid the cycle after rd_en
    logic [9:0]            xoff;
    logic [9:0]            yoff;
    logic                  ghf;
    logic                  gvf;

    modport tbl     (input rd_en, rd_idx, output entry, xoff, yoff, ghf, gvf);
    modport scanner (output rd_en, rd_idx);
    modport geom    (input entry, xoff, yoff, ghf, gvf);
endinterface

module sprite_scan_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_we,
    input  logic [`CPU_ADDR_W-1:0] cpu_addr,
    input  logic [`WORD_W-1:0]     cpu_data,
    input  logic                   line_start,
    input  logic [8:0]             vline,
    output logic                   draw_start,
    output logic [`WORD_W-1:0]     draw_code,
    output logic [7:0]             draw_attr,
    output logic [8:0]             draw_hpos,
    output logic [3:0]             draw_ysub,
    output logic                   draw_hflip,
    output logic                   draw_vflip,
    input  logic                   draw_busy,
    output logic                   line_done
);

    logic       load, advance, eval, last, in_zone;
    logic [2:0] step;
    logic [8:0] line;

    obj_rd_if rd_bus ();

    obj_table obj_table_inst (
        .clk, .rst, .cpu_we, .cpu_addr, .cpu_data,
        .rd (rd_bus.tbl)
    );

    tile_step_counter tile_step_counter_inst (
        .clk, .rst, .load,
        .hsz (rd_bus.entry.hsz),
        .advance, .step, .last
    );

    obj_geom obj_geom_inst (
        .clk, .rst,
        .rd        (rd_bus.geom),
        .line, .eval, .step, .in_zone,
        .code      (draw_code),
        .hpos      (draw_hpos),
        .ysub      (draw_ysub),
        .eff_hflip (draw_hflip),
        .eff_vflip (draw_vflip)
    );

    scan_fsm scan_fsm_inst (
        .clk, .rst, .line_start, .vline,
        .rd (rd_bus.scanner),
        .in_zone, .last, .load, .advance, .eval, .line,
        .draw_start, .draw_busy, .line_done
    );

    assign draw_attr = rd_bus.entry.attr;  // entry holds until the next read

endmodule

/* tb/sprite_scan_tb.sv */
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_scan_tb;

    localparam int LINE_TIMEOUT = 8000;  // full table with long busy
    localparam int ABORT_CYCLES = 30;    // far below any complete scan

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   cpu_we;
    logic [`CPU_ADDR_W-1:0] cpu_addr;
    logic [`WORD_W-1:0]     cpu_data;
    logic                   line_start;
    logic [8:0]             vline;
    logic                   draw_start;
    logic [`WORD_W-1:0]     draw_code;
    logic [7:0]             draw_attr;
    logic [8:0]             draw_hpos;
    logic [3:0]             draw_ysub;
    logic                   draw_hflip;
    logic                   draw_vflip;
    logic                   draw_busy = 1'b0;
    logic                   line_done;

    // request record {code, attr, hpos, ysub, hflip, vflip}
    logic [38:0] captured [$];
    logic [38:0] expected [$];

    logic [31:0] rng = 32'h3eed_da5a;
    int          busy_left;
    int          fd;
    string       test_name = "setup";

    sprite_scan_top sprite_scan_top_inst (
        .clk, .rst, .cpu_we, .cpu_addr, .cpu_data,
        .line_start, .vline,
        .draw_start, .draw_code, .draw_attr, .draw_hpos, .draw_ysub,
        .draw_hflip, .draw_vflip, .draw_busy, .line_done
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // drawer model, busy for 0 to 5 cycles after each request
    always @(posedge clk, posedge rst) begin
        if (rst) begin
            draw_busy <= 1'b0;
            busy_left <= 0;
        end else if (draw_start) begin
            rng = xorshift32(rng);
            busy_left <= rng % 6;
            draw_busy <= (rng % 6) != 0;
        end else if (busy_left > 1) begin
            busy_left <= busy_left - 1;
        end else begin
            busy_left <= 0;
            draw_busy <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst && draw_start)
            captured.push_back({draw_code, draw_attr, draw_hpos, draw_ysub,
                                draw_hflip, draw_vflip});
    end

    task automatic report_and_stop(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            report_and_stop($sformatf("FAILED %s, %s expected %0h actual %0h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic cpu_write(input logic [`CPU_ADDR_W-1:0] addr,
                             input logic [`WORD_W-1:0] data);
        @(posedge clk);
        cpu_we   <= 1'b1;
        cpu_addr <= addr;
        cpu_data <= data;
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    task automatic pulse_line(input logic [8:0] v);
        @(posedge clk);
        line_start <= 1'b1;
        vline      <= v;
        @(posedge clk);
        line_start <= 1'b0;
        @(posedge clk);
        captured.delete();  // scanner is in read here, old scan is gone
    endtask

    task automatic wait_line_done();
        int cycles;
        cycles = 0;
        while (!line_done && cycles < LINE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (line_done) else begin
            report_and_stop($sformatf("line_done did not arrive within %0d cycles in %s",
                                      LINE_TIMEOUT, test_name));
        end
    endtask

    task automatic compare_draws();
        check_value("request count", expected.size(), captured.size());
        foreach (expected[i]) begin
            check_value($sformatf("code %0d", i), expected[i][38:23], captured[i][38:23]);
            check_value($sformatf("attr %0d", i), expected[i][22:15], captured[i][22:15]);
            check_value($sformatf("hpos %0d", i), expected[i][14:6], captured[i][14:6]);
            check_value($sformatf("ysub %0d", i), expected[i][5:2], captured[i][5:2]);
            check_value($sformatf("hflip %0d", i), expected[i][1], captured[i][1]);
            check_value($sformatf("vflip %0d", i), expected[i][0], captured[i][0]);
        end
    endtask

    // next data line, a # line renames the running test
    task automatic read_record(output bit found, output string text);
        string raw;
        int    n;
        found = 1'b0;
        n     = 1;
        while (!found && n != 0) begin
            n = $fgets(raw, fd);
            if (n != 0) begin
                while (raw.len() > 0 && raw.getc(raw.len() - 1) <= 8'h20)
                    raw = raw.substr(0, raw.len() - 2);
                if (raw.len() > 1 && raw.getc(0) == 8'h23) begin
                    test_name = raw.substr(2, raw.len() - 1);
                end else if (raw.len() > 0) begin
                    text  = raw;
                    found = 1'b1;
                end
            end
        end
    endtask

    initial begin
        string       text;
        bit          found;
        logic [7:0]  kind;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        logic [8:0]  v;
        int          count;
        int          n;
        int          i;
        rst        = 1'b1;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_data   = '0;
        line_start = 1'b0;
        vline      = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < `OBJ_COUNT; i++)
            cpu_write(`CPU_ADDR_W'(i * 4), '0);  // every object inactive
        fd = $fopen("tb/sprite_testdata.txt", "r");
        assert (fd != 0) else report_and_stop("cannot open tb/sprite_testdata.txt");
        read_record(found, text);
        while (found) begin
            n = $sscanf(text, "%c %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5);
            if (kind == "w") begin
                cpu_write(f0[`CPU_ADDR_W-1:0], f1[`WORD_W-1:0]);
            end else if (kind == "l" && f1 == 32'hff) begin
                pulse_line(f0[8:0]);
                repeat (ABORT_CYCLES) @(posedge clk);  // scan left unfinished
            end else if (kind == "l") begin
                v     = f0[8:0];
                count = f1;
                expected.delete();
                for (i = 0; i < count; i++) begin
                    read_record(found, text);
                    n = $sscanf(text, "%c %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5);
                    assert (found && kind == "d" && n == 7) else begin
                        report_and_stop($sformatf("missing request record in %s", test_name));
                    end
                    expected.push_back({f0[15:0], f1[7:0], f2[8:0], f3[3:0], f4[0], f5[0]});
                end
                pulse_line(v);
                wait_line_done();
                compare_draws();
            end else begin
                report_and_stop($sformatf("unknown record in stimulus file: %s", text));
            end
            read_record(found, text);
        end
        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule

/* sprite_scan.f */
+incdir+include
logic/sprite_pkg.sv
logic/obj_table.sv
logic/tile_step_counter.sv
logic/obj_geom.sv
logic/scan_fsm.sv
logic/sprite_scan_top.sv
tb/sprite_scan_tb.sv

/* Bender.yml */
package:
  name: sprite_scan

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/sprite_pkg.sv
      - logic/obj_table.sv
      - logic/tile_step_counter.sv
      - logic/obj_geom.sv
      - logic/scan_fsm.sv
      - logic/sprite_scan_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/sprite_scan_tb.sv

/* tb/sprite_testdata.txt */
# w addr data | l vline count | d code attr hpos ysub hflip vflip
# all fields hex, count ff leaves the scan unfinished, a # line names the checks below it
# table setup
w 000 0055
w 001 0020
w 004 8001
w 005 0020
w 006 0010
w 007 0100
w 008 8402
w 009 0030
w 00a 0020
w 00b 0200
w 00c 8803
w 00d 0050
w 00e 0030
w 00f 0300
w 010 8c04
w 011 0090
w 012 0040
w 013 0400
w 014 8315
w 015 0180
w 016 0100
w 017 1000
w 018 b526
w 019 01a0
w 01a 00f8
w 01b 2000
# vertical zone and inactive object
l 01f 0
l 020 1
d 0100 01 010 0 0 0
l 02f 1
d 0100 01 010 f 0 0
l 030 1
d 0200 02 020 0 0 0
l 04f 1
d 0208 02 020 f 0 0
l 050 1
d 0300 03 030 0 0 0
l 08f 1
d 0318 03 030 f 0 0
l 090 1
d 0400 04 040 0 0 0
l 10f 1
d 0438 04 040 f 0 0
l 110 0
# eight tile columns
l 185 8
d 1000 15 100 5 0 0
d 1001 15 110 5 0 0
d 1002 15 120 5 0 0
d 1003 15 130 5 0 0
d 1004 15 140 5 0 0
d 1005 15 150 5 0 0
d 1006 15 160 5 0 0
d 1007 15 170 5 0 0
# object flips
l 1a3 2
d 2009 26 0f8 c 1 1
d 2008 26 108 c 1 1
# global hflip against object flips
w 102 0001
l 1a3 2
d 2008 26 0f8 c 0 1
d 2009 26 108 c 0 1
# scroll offsets
w 102 0000
w 100 0008
w 101 0010
l 193 2
d 2009 26 0f0 c 1 1
d 2008 26 100 c 1 1
# restart during a scan
l 175 ff
l 193 2
d 2009 26 0f0 c 1 1
d 2008 26 100 c 1 1
